// File: design/lc4_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, opcodes and instruction views for the LC4
// integer pipeline. Only the ALU subset is decoded here, so
// loads, stores, branches, MUL, DIV, MOD and shifts have no
// codes and retire as NOPs
////////////////////////////////////////////////////////////
`default_nettype none

package lc4_pkg;

   localparam int WORD_W = 16;          // Data and instruction width
   localparam int SEL_W  = 3;           // Register select width
   localparam int NREGS  = 8;
   localparam int NZP_W  = 3;

   // Condition codes, one-hot
   localparam logic [NZP_W-1:0] NZP_N = 3'b100;
   localparam logic [NZP_W-1:0] NZP_Z = 3'b010;
   localparam logic [NZP_W-1:0] NZP_P = 3'b001;

   // Major opcodes, insn[15:12]
   localparam logic [3:0] OPC_NOP     = 4'b0000;
   localparam logic [3:0] OPC_ARITH   = 4'b0001;
   localparam logic [3:0] OPC_LOGIC   = 4'b0101;
   localparam logic [3:0] OPC_CONST   = 4'b1001;
   localparam logic [3:0] OPC_HICONST = 4'b1101;

   // Sub-operations, insn[5:3]; bit 5 high means immediate form
   localparam logic [2:0] SUB_ADD = 3'b000;   // ARITH
   localparam logic [2:0] SUB_SUB = 3'b010;   // ARITH
   localparam logic [2:0] SUB_AND = 3'b000;   // LOGIC
   localparam logic [2:0] SUB_NOT = 3'b001;   // LOGIC
   localparam logic [2:0] SUB_OR  = 3'b010;   // LOGIC
   localparam logic [2:0] SUB_XOR = 3'b011;   // LOGIC

   // One instruction word, three field layouts
   typedef union packed {
      struct packed {
         logic [3:0] opcode;
         logic [2:0] rd;
         logic [2:0] rs;
         logic [2:0] sub;
         logic [2:0] rt;
      } r;                               // Register form
      struct packed {
         logic [3:0] opcode;
         logic [2:0] rd;
         logic [2:0] rs;
         logic       imm_flag;
         logic [4:0] imm5;
      } i;                               // Immediate form
      struct packed {
         logic [3:0] opcode;
         logic [2:0] rd;
         logic [8:0] imm9;              // HICONST uses [7:0]
      } c;                               // Constant form
   } insn_u;

   localparam logic [WORD_W-1:0] NOP_INSN = '0;

endpackage

`default_nettype wire

// File: design/lc4_x_if.sv
////////////////////////////////////////////////////////////
// Decoded instruction leaving the D stage toward execute.
// Read data already carries the WD bypass. No handshake,
// the receiver samples on every edge of gwe
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface lc4_x_if;
   import lc4_pkg::*;

   logic              valid;
   logic [WORD_W-1:0] pc;
   logic [WORD_W-1:0] insn;
   logic [SEL_W-1:0]  rs_sel;
   logic [SEL_W-1:0]  rt_sel;
   logic [SEL_W-1:0]  rd_sel;
   logic              rd_we;      // Only for kept operations
   logic [WORD_W-1:0] rs_data;
   logic [WORD_W-1:0] rt_data;

   modport decode  (output valid, pc, insn, rs_sel, rt_sel, rd_sel, rd_we, rs_data, rt_data);
   modport execute (input  valid, pc, insn, rs_sel, rt_sel, rd_sel, rd_we, rs_data, rt_data);

endinterface

`default_nettype wire

// File: design/lc4_m_if.sv
////////////////////////////////////////////////////////////
// Executed instruction held in the M register, on its way
// to the W stage. No data memory, so the written value is
// always the ALU output
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface lc4_m_if;
   import lc4_pkg::*;

   logic              valid;
   logic [WORD_W-1:0] pc;
   logic [WORD_W-1:0] insn;
   logic [SEL_W-1:0]  rd_sel;
   logic              rd_we;
   logic [WORD_W-1:0] alu_result; // ALU output

   modport execute (output valid, pc, insn, rd_sel, rd_we, alu_result);
   modport result  (input  valid, pc, insn, rd_sel, rd_we, alu_result);

endinterface

`default_nettype wire

// File: design/lc4_regfile.sv
////////////////////////////////////////////////////////////
// Eight 16-bit registers, two async read ports, one write
// port. A write lands on the edge, so a read in the same
// cycle sees the old value; the caller bypasses if needed
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_regfile (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   input  wire  [lc4_pkg::SEL_W-1:0]   i_rs_sel,
   input  wire  [lc4_pkg::SEL_W-1:0]   i_rt_sel,
   output logic [lc4_pkg::WORD_W-1:0]  o_rs_data,
   output logic [lc4_pkg::WORD_W-1:0]  o_rt_data,
   input  wire  [lc4_pkg::SEL_W-1:0]   i_rd_sel,
   input  wire  [lc4_pkg::WORD_W-1:0]  i_wdata,
   input  wire                         i_we
);
   import lc4_pkg::*;

   logic [WORD_W-1:0] regs [NREGS];

   // All registers read 0 after reset
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   assign o_rs_data = regs[i_rs_sel];   // Async read
   assign o_rt_data = regs[i_rt_sel];

endmodule

`default_nettype wire

// File: design/lc4_decode.sv
////////////////////////////////////////////////////////////
// Fetch and decode. PC advances by one on every edge, there
// is no branch or stall path. D register feeds the X bus
// combinationally; writeback inputs are W-stage values and
// drive both the register file write and the WD bypass
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_decode #(
   parameter logic [lc4_pkg::WORD_W-1:0] RESET_PC = 16'h8200
) (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   output logic [lc4_pkg::WORD_W-1:0]  o_cur_pc,     // To instruction memory
   input  wire  [lc4_pkg::WORD_W-1:0]  i_cur_insn,
   input  wire                         i_wb_we,
   input  wire  [lc4_pkg::SEL_W-1:0]   i_wb_sel,
   input  wire  [lc4_pkg::WORD_W-1:0]  i_wb_data,
   lc4_x_if.decode                     x_bus
);
   import lc4_pkg::*;

   logic [WORD_W-1:0] pc_q;
   logic [WORD_W-1:0] d_pc;
   logic [WORD_W-1:0] d_insn;
   logic              d_valid;
   insn_u             d_view;
   logic [SEL_W-1:0]  rs_sel;
   logic [SEL_W-1:0]  rt_sel;
   logic              kept;          // Operation writes rd
   logic [WORD_W-1:0] rf_rs_data;
   logic [WORD_W-1:0] rf_rt_data;

   // F stage is just the PC; D register captures the fetched word
   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q    <= RESET_PC;
         d_valid <= 1'b0;
         d_insn  <= NOP_INSN;
      end else begin
         pc_q    <= pc_q + 1'b1;
         d_valid <= 1'b1;           // Every fetched slot is real
         d_insn  <= i_cur_insn;
      end
   end

   always_ff @(posedge gwe) begin
      d_pc <= pc_q;                 // Payload only
   end

   assign o_cur_pc = pc_q;
   assign d_view   = d_insn;

   // HICONST merges into rd, so rd is read on the rs port
   assign rs_sel = (d_view.r.opcode == OPC_HICONST) ? d_view.r.rd : d_view.r.rs;
   assign rt_sel = d_view.r.rt;

   always_comb begin
      case (d_view.r.opcode)
         OPC_NOP:     kept = 1'b0;
         OPC_ARITH:   kept = d_view.i.imm_flag ||
                             (d_view.r.sub == SUB_ADD) || (d_view.r.sub == SUB_SUB);
         OPC_LOGIC:   kept = 1'b1;      // AND NOT OR XOR and AND-imm cover all codes
         OPC_CONST:   kept = 1'b1;
         OPC_HICONST: kept = 1'b1;
         default:     kept = 1'b0;      // Dropped opcodes retire as NOP
      endcase
   end

   lc4_regfile regfile_i (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (rt_sel),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data),
      .i_rd_sel  (i_wb_sel),
      .i_wdata   (i_wb_data),
      .i_we      (i_wb_we)
   );

   assign x_bus.valid  = d_valid;
   assign x_bus.pc     = d_pc;
   assign x_bus.insn   = d_insn;
   assign x_bus.rs_sel = rs_sel;
   assign x_bus.rt_sel = rt_sel;
   assign x_bus.rd_sel = d_view.r.rd;
   assign x_bus.rd_we  = d_valid && kept;

   // WD bypass, write and read in the same cycle
   assign x_bus.rs_data = (i_wb_we && (i_wb_sel == rs_sel)) ? i_wb_data : rf_rs_data;
   assign x_bus.rt_data = (i_wb_we && (i_wb_sel == rt_sel)) ? i_wb_data : rf_rt_data;

endmodule

`default_nettype wire

// File: design/lc4_execute.sv
////////////////////////////////////////////////////////////
// X register, MX and WX operand bypass, ALU, M register.
// MX wins over WX since it holds the younger producer.
// Dropped sub-operations produce 0 with rd_we already low
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_execute (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   lc4_x_if.execute                    x_bus,
   input  wire                         i_wb_we,
   input  wire  [lc4_pkg::SEL_W-1:0]   i_wb_sel,
   input  wire  [lc4_pkg::WORD_W-1:0]  i_wb_data,
   lc4_m_if.execute                    m_bus
);
   import lc4_pkg::*;

   logic              x_valid, x_rd_we;
   logic [WORD_W-1:0] x_pc, x_insn, x_rs_data, x_rt_data;
   logic [SEL_W-1:0]  x_rs_sel, x_rt_sel, x_rd_sel;
   insn_u             x_view;
   logic [WORD_W-1:0] op_a, op_b;     // After bypass
   logic [WORD_W-1:0] imm5_sx, imm9_sx;
   logic [WORD_W-1:0] alu_out;
   logic              m_valid, m_rd_we;
   logic [WORD_W-1:0] m_pc, m_insn, m_result;
   logic [SEL_W-1:0]  m_rd_sel;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         x_valid <= 1'b0;
         x_rd_we <= 1'b0;
         m_valid <= 1'b0;
         m_rd_we <= 1'b0;
      end else begin
         x_valid <= x_bus.valid;
         x_rd_we <= x_bus.rd_we;
         m_valid <= x_valid;
         m_rd_we <= x_rd_we;
      end
   end

   // Payload side of the X and M registers
   always_ff @(posedge gwe) begin
      x_pc      <= x_bus.pc;
      x_insn    <= x_bus.insn;
      x_rs_sel  <= x_bus.rs_sel;
      x_rt_sel  <= x_bus.rt_sel;
      x_rd_sel  <= x_bus.rd_sel;
      x_rs_data <= x_bus.rs_data;
      x_rt_data <= x_bus.rt_data;
      m_pc      <= x_pc;
      m_insn    <= x_insn;
      m_rd_sel  <= x_rd_sel;
      m_result  <= alu_out;
   end

   // MX first, then WX, then the value read in D
   assign op_a = (m_rd_we && (m_rd_sel == x_rs_sel)) ? m_result  :
                 (i_wb_we && (i_wb_sel == x_rs_sel)) ? i_wb_data : x_rs_data;
   assign op_b = (m_rd_we && (m_rd_sel == x_rt_sel)) ? m_result  :
                 (i_wb_we && (i_wb_sel == x_rt_sel)) ? i_wb_data : x_rt_data;

   assign x_view  = x_insn;
   assign imm5_sx = {{(WORD_W-5){x_view.i.imm5[4]}}, x_view.i.imm5};
   assign imm9_sx = {{(WORD_W-9){x_view.c.imm9[8]}}, x_view.c.imm9};

   always_comb begin
      alu_out = '0;
      case (x_view.r.opcode)
         OPC_ARITH: begin
            if (x_view.i.imm_flag) alu_out = op_a + imm5_sx;     // ADD imm, wraps
            else if (x_view.r.sub == SUB_ADD) alu_out = op_a + op_b;
            else if (x_view.r.sub == SUB_SUB) alu_out = op_a - op_b;
         end
         OPC_LOGIC: begin
            if (x_view.i.imm_flag) begin
               alu_out = op_a & imm5_sx;
            end else begin
               case (x_view.r.sub)
                  SUB_AND: alu_out = op_a & op_b;
                  SUB_NOT: alu_out = ~op_a;
                  SUB_OR:  alu_out = op_a | op_b;
                  SUB_XOR: alu_out = op_a ^ op_b;
                  default: alu_out = '0;
               endcase
            end
         end
         OPC_CONST:   alu_out = imm9_sx;
         OPC_HICONST: alu_out = {x_view.c.imm9[7:0], op_a[7:0]};  // Keep rd low byte
         default:     alu_out = '0;
      endcase
   end

   assign m_bus.valid      = m_valid;
   assign m_bus.pc         = m_pc;
   assign m_bus.insn       = m_insn;
   assign m_bus.rd_sel     = m_rd_sel;
   assign m_bus.rd_we      = m_rd_we;
   assign m_bus.alu_result = m_result;

endmodule

`default_nettype wire

// File: design/lc4_result.sv
////////////////////////////////////////////////////////////
// W register and retire trace. NZP bits are computed from
// the written value but not stored, no branch reads them.
// Every kept writing instruction also sets NZP
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_result (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   lc4_m_if.result                     m_bus,
   output logic                        o_wb_we,
   output logic [lc4_pkg::SEL_W-1:0]   o_wb_sel,
   output logic [lc4_pkg::WORD_W-1:0]  o_wb_data,
   output logic                        o_retire_valid,
   output logic [lc4_pkg::WORD_W-1:0]  o_retire_pc,
   output logic [lc4_pkg::WORD_W-1:0]  o_retire_insn,
   output logic                        o_nzp_we,
   output logic [lc4_pkg::NZP_W-1:0]   o_nzp_new_bits
);
   import lc4_pkg::*;

   logic              w_valid, w_rd_we;
   logic [WORD_W-1:0] w_pc, w_insn, w_data;
   logic [SEL_W-1:0]  w_rd_sel;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         w_valid <= 1'b0;
         w_rd_we <= 1'b0;
      end else begin
         w_valid <= m_bus.valid;
         w_rd_we <= m_bus.rd_we;
      end
   end

   always_ff @(posedge gwe) begin
      w_pc     <= m_bus.pc;
      w_insn   <= m_bus.insn;
      w_rd_sel <= m_bus.rd_sel;
      w_data   <= m_bus.alu_result;
   end

   // Zero, then sign bit
   assign o_nzp_new_bits = (w_data == '0)     ? NZP_Z :
                           w_data[WORD_W-1]   ? NZP_N : NZP_P;
   assign o_nzp_we       = w_rd_we;

   assign o_wb_we        = w_rd_we;      // Regfile write lands next edge
   assign o_wb_sel       = w_rd_sel;
   assign o_wb_data      = w_data;
   assign o_retire_valid = w_valid;
   assign o_retire_pc    = w_pc;
   assign o_retire_insn  = w_insn;

endmodule

`default_nettype wire

// File: design/lc4_core.sv
////////////////////////////////////////////////////////////
// LC4 five-stage pipeline top, ALU subset only. No stalls,
// no back-pressure, no data memory port. An insn taken at
// edge k retires after edge k+3 and writes at edge k+4.
// RESET_PC may be any value
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_core #(
   parameter logic [lc4_pkg::WORD_W-1:0] RESET_PC = 16'h8200
) (
   input  wire                         gwe,
   input  wire                         i_rst_n,
   output logic [lc4_pkg::WORD_W-1:0]  o_cur_pc,
   input  wire  [lc4_pkg::WORD_W-1:0]  i_cur_insn,
   output logic                        o_retire_valid,
   output logic [lc4_pkg::WORD_W-1:0]  o_retire_pc,
   output logic [lc4_pkg::WORD_W-1:0]  o_retire_insn,
   output logic                        o_regfile_we,
   output logic [lc4_pkg::SEL_W-1:0]   o_regfile_wsel,
   output logic [lc4_pkg::WORD_W-1:0]  o_regfile_data,
   output logic                        o_nzp_we,
   output logic [lc4_pkg::NZP_W-1:0]   o_nzp_new_bits
);
   import lc4_pkg::*;

   logic              wb_we;         // W-stage writeback, fed back to D and X
   logic [SEL_W-1:0]  wb_sel;
   logic [WORD_W-1:0] wb_data;

   lc4_x_if x_bus ();
   lc4_m_if m_bus ();

   lc4_decode #(.RESET_PC(RESET_PC)) decode_i (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .o_cur_pc   (o_cur_pc),
      .i_cur_insn (i_cur_insn),
      .i_wb_we    (wb_we),
      .i_wb_sel   (wb_sel),
      .i_wb_data  (wb_data),
      .x_bus      (x_bus.decode)
   );

   lc4_execute execute_i (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .x_bus     (x_bus.execute),
      .i_wb_we   (wb_we),
      .i_wb_sel  (wb_sel),
      .i_wb_data (wb_data),
      .m_bus     (m_bus.execute)
   );

   lc4_result result_i (
      .gwe            (gwe),
      .i_rst_n        (i_rst_n),
      .m_bus          (m_bus.result),
      .o_wb_we        (wb_we),
      .o_wb_sel       (wb_sel),
      .o_wb_data      (wb_data),
      .o_retire_valid (o_retire_valid),
      .o_retire_pc    (o_retire_pc),
      .o_retire_insn  (o_retire_insn),
      .o_nzp_we       (o_nzp_we),
      .o_nzp_new_bits (o_nzp_new_bits)
   );

   // Retire trace shows the write as it goes to the register file
   assign o_regfile_we   = wb_we;
   assign o_regfile_wsel = wb_sel;
   assign o_regfile_data = wb_data;

endmodule

`default_nettype wire

// File: dv/lc4_core_properties.sv
////////////////////////////////////////////////////////////
// Port-level checks, bound into every lc4_core instance.
// Sampled on the rising edge of gwe. Reset is async, so
// retire valid is already low at the first sampled edge
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_core_properties (
   input wire                         gwe,
   input wire                         i_rst_n,
   input wire [lc4_pkg::WORD_W-1:0]   i_cur_pc,
   input wire                         i_retire_valid,
   input wire                         i_regfile_we,
   input wire [lc4_pkg::WORD_W-1:0]   i_regfile_data,
   input wire                         i_nzp_we,
   input wire [lc4_pkg::NZP_W-1:0]    i_nzp_bits
);
   int fail_count = 0;

   retire_low_in_reset: assert property (@(posedge gwe) !i_rst_n |-> !i_retire_valid)
      else begin
         $error("Retire valid high during reset");
         fail_count++;
      end

   // A write only comes with a retiring instruction
   regfile_we_retires: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_regfile_we |-> i_retire_valid)
      else begin
         $error("Register write without retire valid");
         fail_count++;
      end

   nzp_we_retires: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_nzp_we |-> i_retire_valid)
      else begin
         $error("NZP write without retire valid");
         fail_count++;
      end

   // One-hot code that agrees with the written value
   nzp_onehot: assert property (@(posedge gwe) disable iff (!i_rst_n)
      i_nzp_we |-> $onehot(i_nzp_bits) && (i_nzp_bits[1] == (i_regfile_data == '0)) &&
                   (i_nzp_bits[2] == i_regfile_data[lc4_pkg::WORD_W-1]))
      else begin
         $error("NZP bits %b do not match data %h", i_nzp_bits, i_regfile_data);
         fail_count++;
      end

   // Sequential fetch, first edge after release is skipped
   pc_steps_by_one: assert property (@(posedge gwe) disable iff (!i_rst_n)
      $past(i_rst_n) |-> i_cur_pc == $past(i_cur_pc) + 16'd1)
      else begin
         $error("PC did not advance by one");
         fail_count++;
      end

endmodule

bind lc4_core lc4_core_properties props_i (
   .gwe            (gwe),
   .i_rst_n        (i_rst_n),
   .i_cur_pc       (o_cur_pc),
   .i_retire_valid (o_retire_valid),
   .i_regfile_we   (o_regfile_we),
   .i_regfile_data (o_regfile_data),
   .i_nzp_we       (o_nzp_we),
   .i_nzp_bits     (o_nzp_new_bits)
);

`default_nettype wire

// File: dv/lc4_core_tb.sv
////////////////////////////////////////////////////////////
// Directed tests for the LC4 ALU pipeline. Instruction memory
// is a program array indexed by o_cur_pc - RESET_PC, up to 64
// words; every other address reads as NOP. Each test starts
// from its own reset and a register model checks every retire
// in program order
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lc4_core_tb;
   import lc4_pkg::*;

   localparam logic [15:0] RESET_PC = 16'h8200;

   logic        gwe = 1'b0;
   logic        i_rst_n;
   logic [15:0] i_cur_insn;
   logic [15:0] o_cur_pc, o_retire_pc, o_retire_insn, o_regfile_data;
   logic        o_retire_valid, o_regfile_we, o_nzp_we;
   logic [2:0]  o_regfile_wsel, o_nzp_new_bits;

   logic [15:0] prog [64];           // Instruction memory image
   logic [15:0] ref_regs [8];        // Architectural model
   logic [15:0] exp_pc;              // PC of the next expected retire
   int          prog_len, prog_retired;
   int          errors, checks, tests, test_err0, test_chk0;
   string       cur_test;

   always #5 gwe = ~gwe;             // 10 ns period

   lc4_core #(.RESET_PC(RESET_PC)) dut_i (
      .gwe            (gwe),
      .i_rst_n        (i_rst_n),
      .o_cur_pc       (o_cur_pc),
      .i_cur_insn     (i_cur_insn),
      .o_retire_valid (o_retire_valid),
      .o_retire_pc    (o_retire_pc),
      .o_retire_insn  (o_retire_insn),
      .o_regfile_we   (o_regfile_we),
      .o_regfile_wsel (o_regfile_wsel),
      .o_regfile_data (o_regfile_data),
      .o_nzp_we       (o_nzp_we),
      .o_nzp_new_bits (o_nzp_new_bits)
   );

   task automatic check_equal(input string what, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("Error: test %s, %s expected %h actual %h at %0t",
                  cur_test, what, expected, actual, $time);
      end
   endtask

   // Instruction encoders
   function automatic logic [15:0] reg_form(input logic [3:0] opc, input int rd, input int rs,
                                            input logic [2:0] sub, input int rt);
      return {opc, 3'(rd), 3'(rs), sub, 3'(rt)};
   endfunction

   function automatic logic [15:0] imm_form(input logic [3:0] opc, input int rd, input int rs,
                                            input int imm);
      return {opc, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
   endfunction

   function automatic logic [15:0] const_insn(input int rd, input int imm);
      return {OPC_CONST, 3'(rd), 9'(imm)};
   endfunction

   function automatic logic [15:0] hiconst_insn(input int rd, input int imm8);
      return {OPC_HICONST, 3'(rd), 1'b1, 8'(imm8)};
   endfunction

   function automatic void emit(input logic [15:0] insn);
      prog[6'(prog_len)] = insn;
      prog_len++;
   endfunction

   function automatic logic [15:0] insn_at(input logic [15:0] pc);
      logic [15:0] idx;
      idx = pc - RESET_PC;
      if (int'(idx) < prog_len) return prog[idx[5:0]];
      return NOP_INSN;                // Past the program
   endfunction

   function automatic logic [2:0] nzp_of(input logic [15:0] v);
      if (v == 16'd0) return NZP_Z;
      if (v[15]) return NZP_N;
      return NZP_P;
   endfunction

   // ISA rules for the kept subset, everything else writes nothing
   function automatic void model_step(input logic [15:0] insn, output logic we,
                                      output logic [15:0] val);
      logic [15:0] a, b, imm5x;
      a     = ref_regs[insn[8:6]];
      b     = ref_regs[insn[2:0]];
      imm5x = {{11{insn[4]}}, insn[4:0]};
      we    = 1'b1;
      val   = '0;
      case (insn[15:12])
         OPC_ARITH:
            if (insn[5]) val = a + imm5x;
            else if (insn[5:3] == SUB_ADD) val = a + b;
            else if (insn[5:3] == SUB_SUB) val = a - b;
            else we = 1'b0;           // MUL, DIV
         OPC_LOGIC:
            if (insn[5]) begin
               val = a & imm5x;
            end else begin
               case (insn[5:3])
                  SUB_AND: val = a & b;
                  SUB_NOT: val = ~a;
                  SUB_OR:  val = a | b;
                  SUB_XOR: val = a ^ b;
                  default: we = 1'b0;
               endcase
            end
         OPC_CONST:   val = {{7{insn[8]}}, insn[8:0]};
         OPC_HICONST: val = {insn[7:0], ref_regs[insn[11:9]][7:0]};   // rd low byte kept
         default:     we = 1'b0;
      endcase
   endfunction

   task automatic check_retire();
      logic [15:0] insn, val, idx;
      logic        we;
      insn = insn_at(exp_pc);
      idx  = exp_pc - RESET_PC;
      model_step(insn, we, val);
      check_equal("retire_pc", exp_pc, o_retire_pc);
      check_equal("retire_insn", insn, o_retire_insn);
      check_equal("regfile_we", 16'(we), 16'(o_regfile_we));
      check_equal("nzp_we", 16'(we), 16'(o_nzp_we));
      if (we) begin
         check_equal("regfile_wsel", 16'(insn[11:9]), 16'(o_regfile_wsel));
         check_equal("regfile_data", val, o_regfile_data);
         check_equal("nzp_bits", 16'(nzp_of(val)), 16'(o_nzp_new_bits));
         ref_regs[insn[11:9]] = val;
      end
      if (int'(idx) < prog_len) prog_retired++;
      exp_pc = exp_pc + 16'd1;
   endtask

   // Outputs are registered, so they are stable at the falling edge
   task automatic step_cycle();
      @(negedge gwe);
      i_cur_insn = insn_at(o_cur_pc);
      if (o_retire_valid) check_retire();
   endtask

   task automatic reset_dut();
      i_rst_n = 1'b0;
      for (int i = 0; i < 5; i++) begin
         @(negedge gwe);
         i_cur_insn = insn_at(o_cur_pc);
      end
      i_rst_n      = 1'b1;
      ref_regs     = '{default: '0};
      exp_pc       = RESET_PC;
      prog_retired = 0;
      check_equal("cur_pc after reset", RESET_PC, o_cur_pc);
      check_equal("retire_valid after reset", 16'd0, 16'(o_retire_valid));
   endtask

   task automatic run_to_end();
      int cycles;
      cycles = 0;
      while (prog_retired < prog_len && cycles < prog_len + 10) begin
         step_cycle();
         cycles++;
      end
      if (prog_retired < prog_len) begin
         errors++;
         $display("Timeout in test %s: only %0d of %0d instructions retired",
                  cur_test, prog_retired, prog_len);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_err0 = errors;
      test_chk0 = checks;
      prog_len  = 0;
   endtask

   task automatic end_test();
      tests++;
      $display("Test %s finished: %0d checks, %0d errors",
               cur_test, checks - test_chk0, errors - test_err0);
   endtask

   // Retire appears at the 4th falling edge after reset release
   task automatic test_reset_latency();
      begin_test("reset_latency");
      emit(const_insn(1, -42));
      emit(imm_form(OPC_ARITH, 2, 1, 1));
      reset_dut();
      for (int i = 1; i <= 4; i++) begin
         step_cycle();
         check_equal("retire_valid", 16'(i == 4), 16'(o_retire_valid));
      end
      run_to_end();
      end_test();
   endtask

   task automatic test_const_hiconst();
      begin_test("const_hiconst");
      emit(const_insn(1, -1));        // FFFF, N
      emit(const_insn(2, 0));         // Z
      emit(const_insn(3, 255));       // P
      emit(const_insn(4, -256));      // FF00
      emit(hiconst_insn(3, 8'h80));   // 80FF
      emit(hiconst_insn(2, 0));
      emit(hiconst_insn(4, 8'h12));
      reset_dut();
      run_to_end();
      end_test();
   endtask

   task automatic test_alu_ops();
      begin_test("alu_ops");
      emit(const_insn(1, 255));
      emit(hiconst_insn(1, 8'h7F));   // R1 = 7FFF
      emit(const_insn(2, 1));
      emit(const_insn(4, -1));
      emit(reg_form(OPC_ARITH, 3, 1, SUB_ADD, 2));   // Signed overflow
      emit(reg_form(OPC_ARITH, 5, 4, SUB_ADD, 2));   // Wraps to zero
      emit(reg_form(OPC_ARITH, 6, 2, SUB_SUB, 4));
      emit(reg_form(OPC_ARITH, 6, 3, SUB_SUB, 2));   // 8000 - 1
      emit(imm_form(OPC_ARITH, 7, 1, -16));
      emit(imm_form(OPC_ARITH, 7, 4, 15));
      emit(reg_form(OPC_LOGIC, 3, 1, SUB_AND, 4));
      emit(reg_form(OPC_LOGIC, 5, 1, SUB_NOT, 0));
      emit(reg_form(OPC_LOGIC, 6, 1, SUB_OR, 3));
      emit(reg_form(OPC_LOGIC, 7, 1, SUB_XOR, 4));
      emit(imm_form(OPC_LOGIC, 0, 4, -3));
      emit(imm_form(OPC_LOGIC, 0, 1, 10));
      reset_dut();
      run_to_end();
      end_test();
   endtask

   task automatic test_bypass();
      begin_test("bypass");
      emit(const_insn(1, 7));
      emit(reg_form(OPC_ARITH, 2, 1, SUB_ADD, 1));   // Distance 1, MX
      emit(const_insn(3, -5));
      emit(const_insn(6, 1));
      emit(reg_form(OPC_ARITH, 5, 3, SUB_SUB, 0));   // Distance 2, WX
      emit(const_insn(7, 100));
      emit(NOP_INSN);
      emit(NOP_INSN);
      emit(reg_form(OPC_LOGIC, 0, 7, SUB_OR, 6));    // Distance 3, WD
      emit(const_insn(1, 1));
      emit(const_insn(1, 2));
      emit(reg_form(OPC_ARITH, 2, 4, SUB_ADD, 1));   // Younger R1 must win, rt side
      emit(const_insn(5, 8'h34));
      emit(hiconst_insn(5, 8'h12));                   // Own rd through MX
      reset_dut();
      run_to_end();
      end_test();
   endtask

   task automatic test_nop_unsupported();
      logic [15:0] dropped [11] = '{16'h0000, 16'h0E05, 16'h2201, 16'h3E00, 16'h4800,
                                    16'h6283, 16'h7283, 16'h8000, 16'hA230, 16'hC1C0,
                                    16'hF2FF};
      begin_test("nop_unsupported");
      emit(const_insn(1, 11));
      emit(const_insn(2, -7));
      emit(reg_form(OPC_ARITH, 1, 1, 3'b001, 2));    // MUL dropped
      emit(imm_form(OPC_ARITH, 3, 1, 0));            // R1 still 11
      emit(reg_form(OPC_ARITH, 2, 2, 3'b011, 1));    // DIV dropped
      foreach (dropped[i]) emit(dropped[i]);          // Branch, memory, control, MOD
      emit(imm_form(OPC_ARITH, 4, 1, 0));
      emit(imm_form(OPC_ARITH, 5, 2, 0));
      reset_dut();
      run_to_end();
      end_test();
   endtask

   function automatic logic [15:0] random_insn();
      int rd, rs, rt;
      rd = int'($urandom_range(7, 0));
      rs = int'($urandom_range(7, 0));
      rt = int'($urandom_range(7, 0));
      case ($urandom_range(9, 0))
         0: return reg_form(OPC_ARITH, rd, rs, SUB_ADD, rt);
         1: return reg_form(OPC_ARITH, rd, rs, SUB_SUB, rt);
         2: return imm_form(OPC_ARITH, rd, rs, int'($urandom_range(31, 0)));
         3: return reg_form(OPC_LOGIC, rd, rs, SUB_AND, rt);
         4: return reg_form(OPC_LOGIC, rd, rs, SUB_NOT, rt);
         5: return reg_form(OPC_LOGIC, rd, rs, SUB_OR, rt);
         6: return reg_form(OPC_LOGIC, rd, rs, SUB_XOR, rt);
         7: return imm_form(OPC_LOGIC, rd, rs, int'($urandom_range(31, 0)));
         8: return const_insn(rd, int'($urandom_range(511, 0)));
         default: return hiconst_insn(rd, int'($urandom_range(255, 0)));
      endcase
   endfunction

   task automatic test_random_program();
      begin_test("random_program");
      for (int n = 0; n < 40; n++) emit(random_insn());
      reset_dut();
      run_to_end();
      end_test();
   endtask

   initial begin
      void'($urandom(36340));
      i_rst_n    = 1'b0;
      i_cur_insn = NOP_INSN;
      errors     = 0;
      checks     = 0;
      tests      = 0;
      prog_len   = 0;
      test_reset_latency();
      test_const_hiconst();
      test_alu_ops();
      test_bypass();
      test_nop_unsupported();
      test_random_program();
      if (dut_i.props_i.fail_count != 0) begin
         errors++;
         $display("Assertion failures in bound checker: %0d", dut_i.props_i.fail_count);
      end
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
design/lc4_pkg.sv
design/lc4_x_if.sv
design/lc4_m_if.sv
design/lc4_regfile.sv
design/lc4_decode.sv
design/lc4_execute.sv
design/lc4_result.sv
design/lc4_core.sv
dv/lc4_core_properties.sv
dv/lc4_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LC4 pipeline testbench with Verilator, log goes to sim.log
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert --top-module lc4_core_tb -f project.f -o lc4_sim 2>&1 \
   | tee sim.log \
   && ./obj_dir/lc4_sim 2>&1 | tee -a sim.log \
   || echo "Something failed" | tee -a sim.log
if grep -q "Something failed" sim.log; then
   echo "Simulation FAILED, see sim.log"
   exit 1
fi
echo "Simulation passed"
exit 0
